//--- design/vid_pkg.sv
package vid_pkg;

    // Bus command codes
    typedef enum logic [2:0] {
        cmd_idle      = 3'b000,
        cmd_write     = 3'b001,
        cmd_read_req  = 3'b010,
        cmd_read_data = 3'b011,
        cmd_addr      = 3'b100
    } cmd_t;

    // Register map
    localparam logic [31:0] addr_ctrl    = 32'h0000_0000;
    localparam logic [31:0] addr_h1      = 32'h0000_0028; // h_size / h_end
    localparam logic [31:0] addr_h2      = 32'h0000_0030; // hs_start / hs_end
    localparam logic [31:0] addr_v1      = 32'h0000_0038; // v_size / v_end
    localparam logic [31:0] addr_v2      = 32'h0000_0040; // vs_start / vs_end
    localparam logic [31:0] addr_base    = 32'h0000_0048;
    localparam logic [31:0] addr_lineinc = 32'h0000_0050;

    localparam int count_w      = 13;
    localparam int div_w        = 6;  // Pixel divider field width
    localparam int ctrl_en_bit  = 3;
    localparam int ctrl_div_lsb = 4;  // Divider sits in ctrl[9:4]

    localparam int fifo_depth  = 16;
    localparam int fifo_aw     = $clog2(fifo_depth);
    localparam int fifo_thresh = 12;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // Timing register layout with hi field in 25:13 and lo field in 12:0
    typedef struct packed {
        logic [5:0]         spare;
        logic [count_w-1:0] hi;
        logic [count_w-1:0] lo;
    } span_t;

    typedef struct packed {
        logic [7:0] spare;
        pixel_t     pix;
    } pix_word_t;

    // Same bus word seen as a register pair or as a pixel
    typedef union packed {
        span_t     span;
        pix_word_t pixel;
    } bus_word_u;

endpackage

//--- design/bus_decode.sv
`timescale 1ns/1ps

module bus_decode import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  cmd_t               cmd_in,
    input  logic [31:0]        addr_data_in,
    output logic               en,
    output logic [div_w-1:0]   pix_div,
    output logic [count_w-1:0] h_size,
    output logic [count_w-1:0] h_end,
    output logic [count_w-1:0] hs_start,
    output logic [count_w-1:0] hs_end,
    output logic [count_w-1:0] v_size,
    output logic [count_w-1:0] v_end,
    output logic [count_w-1:0] vs_start,
    output logic [count_w-1:0] vs_end,
    output logic [31:0]        base_addr,
    output logic [31:0]        line_inc,
    output logic               rd_valid,
    output pixel_t             rd_pixel
);

    logic [31:0] reg_addr;  // Target of the next data command
    logic        addr_seen;
    bus_word_u   word;

    assign word = addr_data_in;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reg_addr  <= '0;
            addr_seen <= 1'b0;
        end else if (cmd_in == cmd_addr) begin
            reg_addr  <= addr_data_in;
            addr_seen <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en        <= 1'b0;
            pix_div   <= '0;
            h_size    <= '0;
            h_end     <= '0;
            hs_start  <= '0;
            hs_end    <= '0;
            v_size    <= '0;
            v_end     <= '0;
            vs_start  <= '0;
            vs_end    <= '0;
            base_addr <= '0;
            line_inc  <= '0;
        end else if (cmd_in == cmd_write) begin
            case (reg_addr)
                addr_ctrl: begin
                    en      <= addr_data_in[ctrl_en_bit];
                    pix_div <= addr_data_in[ctrl_div_lsb +: div_w];
                end
                addr_h1: begin
                    h_size <= word.span.hi;
                    h_end  <= word.span.lo;
                end
                addr_h2: begin
                    hs_start <= word.span.hi;
                    hs_end   <= word.span.lo;
                end
                addr_v1: begin
                    v_size <= word.span.hi;
                    v_end  <= word.span.lo;
                end
                addr_v2: begin
                    vs_start <= word.span.hi;
                    vs_end   <= word.span.lo;
                end
                addr_base:    base_addr <= addr_data_in;
                addr_lineinc: line_inc  <= addr_data_in;
                default: begin
                end
            endcase
        end
    end

    // Read data goes straight on to the FIFO write port
    assign rd_valid = (cmd_in == cmd_read_data);
    assign rd_pixel = word.pixel.pix;

    a_data_after_addr: assert property (
        @(posedge clk) disable iff (!reset_n)
        (cmd_in == cmd_write) |-> addr_seen
    ) else $error("bus_decode: data command with no address latched");

endmodule

//--- design/scan_timing.sv
`timescale 1ns/1ps

module scan_timing import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               en,
    input  logic [div_w-1:0]   pix_div,
    input  logic [count_w-1:0] h_size,
    input  logic [count_w-1:0] h_end,
    input  logic [count_w-1:0] hs_start,
    input  logic [count_w-1:0] hs_end,
    input  logic [count_w-1:0] v_size,
    input  logic [count_w-1:0] v_end,
    input  logic [count_w-1:0] vs_start,
    input  logic [count_w-1:0] vs_end,
    input  logic               above_thresh,
    output logic               pix_tick,
    output logic               visible,
    output logic               hsync_i,
    output logic               vsync_i,
    output logic               hblank_i,
    output logic               vblank_i
);

    logic [div_w-1:0]   div_cnt;
    logic               running;  // Set once the FIFO has primed
    logic [count_w-1:0] h_cnt;
    logic [count_w-1:0] v_cnt;

    assign pix_tick = running && (div_cnt == pix_div);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            div_cnt <= '0;
            running <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (!en) begin
            div_cnt <= '0;
            running <= 1'b0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end else if (!running) begin
            running <= above_thresh;
        end else if (pix_tick) begin
            div_cnt <= '0;
            if (h_cnt == h_end) begin
                h_cnt <= '0;
                if (v_cnt == v_end) begin
                    v_cnt <= '0; // Frame wrap
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign hsync_i  = (h_cnt >= hs_start) && (h_cnt < hs_end);
    assign vsync_i  = (v_cnt >= vs_start) && (v_cnt < vs_end);
    assign hblank_i = (h_cnt >= h_size);
    assign vblank_i = (v_cnt >= v_size);
    assign visible  = !hblank_i && !vblank_i;

    // Host must program a nonempty sync window before enabling
    a_hsync_order: assert property (
        @(posedge clk) disable iff (!reset_n)
        en |-> (hs_end > hs_start)
    ) else $error("scan_timing: hs_end not above hs_start while enabled");

endmodule

//--- design/fetch_engine.sv
`timescale 1ns/1ps

module fetch_engine import vid_pkg::*; (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               en,
    input  logic [31:0]        base_addr,
    input  logic [31:0]        line_inc,
    input  logic [count_w-1:0] h_size,
    input  logic [count_w-1:0] v_size,
    input  logic               above_thresh,
    input  logic               rd_valid,
    output logic               req,
    output logic [31:0]        req_addr
);

    logic [count_w-1:0] word_cnt;
    logic [count_w-1:0] line_cnt;
    logic [31:0]        line_start;
    logic [31:0]        next_addr;
    logic               outstanding; // One read in flight
    logic               issue;

    assign issue = en && !outstanding && !above_thresh;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            outstanding <= 1'b0;
        end else if (issue) begin
            outstanding <= 1'b1;
        end else if (rd_valid) begin
            outstanding <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            req        <= 1'b0;
            req_addr   <= '0;
            word_cnt   <= '0;
            line_cnt   <= '0;
            line_start <= '0;
            next_addr  <= '0;
        end else if (!en) begin
            req        <= 1'b0;
            word_cnt   <= '0;
            line_cnt   <= '0;
            line_start <= base_addr;
            next_addr  <= base_addr;
        end else begin
            req <= issue;
            if (issue) begin
                req_addr <= next_addr;
                if (word_cnt == h_size - 1'b1) begin
                    word_cnt <= '0;
                    if (line_cnt == v_size - 1'b1) begin
                        line_cnt   <= '0; // Back to top of frame
                        line_start <= base_addr;
                        next_addr  <= base_addr;
                    end else begin
                        line_cnt   <= line_cnt + 1'b1;
                        line_start <= line_start + line_inc;
                        next_addr  <= line_start + line_inc;
                    end
                end else begin
                    word_cnt  <= word_cnt + 1'b1;
                    next_addr <= next_addr + 32'd4;
                end
            end
        end
    end

    a_no_stray_data: assert property (
        @(posedge clk) disable iff (!reset_n)
        rd_valid |-> outstanding
    ) else $error("fetch_engine: read data with no request outstanding");

endmodule

//--- design/pixel_fifo.sv
`timescale 1ns/1ps

module pixel_fifo import vid_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   en,
    input  logic   rd_valid,
    input  pixel_t rd_pixel,
    input  logic   pop,
    output pixel_t head,
    output logic   full,
    output logic   empty,
    output logic   above_thresh,
    output logic   underflow
);

    pixel_t             mem [fifo_depth];
    logic [fifo_aw:0]   wr_ptr;  // Top bit is the wrap flag
    logic [fifo_aw:0]   rd_ptr;
    logic [fifo_aw:0]   fill;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = en && rd_valid && !full;
    assign rd_en = en && pop && !empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else if (!en) begin
            wr_ptr <= '0; // Flush
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr[fifo_aw-1:0]] <= rd_pixel;
        end
    end

    assign head = mem[rd_ptr[fifo_aw-1:0]];

    // Same index, different wrap bit means full
    assign fill         = wr_ptr - rd_ptr;
    assign empty        = (wr_ptr == rd_ptr);
    assign full         = (wr_ptr[fifo_aw] != rd_ptr[fifo_aw])
                          && (wr_ptr[fifo_aw-1:0] == rd_ptr[fifo_aw-1:0]);
    assign above_thresh = (fill >= fifo_thresh);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            underflow <= 1'b0;
        end else if (!en) begin
            underflow <= 1'b0;
        end else if (pop && empty) begin
            underflow <= 1'b1; // Sticky until disabled
        end
    end

    // Fetch pauses at the threshold, so the FIFO never fills
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!reset_n)
        (en && rd_valid) |-> !full
    ) else $error("pixel_fifo: write while full");

endmodule

//--- design/pixel_out.sv
`timescale 1ns/1ps

module pixel_out import vid_pkg::*; (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       pix_tick,
    input  logic       visible,
    input  logic       hsync_i,
    input  logic       vsync_i,
    input  logic       hblank_i,
    input  logic       vblank_i,
    input  pixel_t     head,
    input  logic       empty,
    input  logic       underflow,
    output logic       pop,
    output logic       hsync,
    output logic       vsync,
    output logic       hblank,
    output logic       vblank,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue,
    output logic       underrun
);

    assign pop = pix_tick && visible;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblank <= 1'b0;
            vblank <= 1'b0;
            red    <= '0;
            green  <= '0;
            blue   <= '0;
        end else if (pix_tick) begin
            hsync  <= hsync_i;
            vsync  <= vsync_i;
            hblank <= hblank_i;
            vblank <= vblank_i;
            if (visible && !empty) begin
                red   <= head.red;
                green <= head.green;
                blue  <= head.blue;
            end else begin
                red   <= '0; // Black in blanking or on underrun
                green <= '0;
                blue  <= '0;
            end
        end
    end

    // Follows the FIFO flag so it also clears when disabled
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            underrun <= 1'b0;
        end else begin
            underrun <= underflow;
        end
    end

endmodule

//--- design/video_ctrl.sv
`timescale 1ns/1ps

module video_ctrl import vid_pkg::*; (
    input  logic        clk,
    input  logic        reset_n,
    input  cmd_t        cmd_in,
    input  logic [31:0] addr_data_in,
    output logic        req,
    output logic [31:0] req_addr,
    output logic        hsync,
    output logic        vsync,
    output logic        hblank,
    output logic        vblank,
    output logic [7:0]  red,
    output logic [7:0]  green,
    output logic [7:0]  blue,
    output logic        underrun
);

    logic               en;
    logic [div_w-1:0]   pix_div;
    logic [count_w-1:0] h_size;
    logic [count_w-1:0] h_end;
    logic [count_w-1:0] hs_start;
    logic [count_w-1:0] hs_end;
    logic [count_w-1:0] v_size;
    logic [count_w-1:0] v_end;
    logic [count_w-1:0] vs_start;
    logic [count_w-1:0] vs_end;
    logic [31:0]        base_addr;
    logic [31:0]        line_inc;
    logic               rd_valid;
    pixel_t             rd_pixel;
    pixel_t             head;
    logic               empty;
    logic               above_thresh;
    logic               underflow;
    logic               pix_tick;
    logic               visible;
    logic               hsync_i;
    logic               vsync_i;
    logic               hblank_i;
    logic               vblank_i;
    logic               pop;

    bus_decode bus_decode_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .cmd_in       (cmd_in),
        .addr_data_in (addr_data_in),
        .en           (en),
        .pix_div      (pix_div),
        .h_size       (h_size),
        .h_end        (h_end),
        .hs_start     (hs_start),
        .hs_end       (hs_end),
        .v_size       (v_size),
        .v_end        (v_end),
        .vs_start     (vs_start),
        .vs_end       (vs_end),
        .base_addr    (base_addr),
        .line_inc     (line_inc),
        .rd_valid     (rd_valid),
        .rd_pixel     (rd_pixel)
    );

    scan_timing scan_timing_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .en           (en),
        .pix_div      (pix_div),
        .h_size       (h_size),
        .h_end        (h_end),
        .hs_start     (hs_start),
        .hs_end       (hs_end),
        .v_size       (v_size),
        .v_end        (v_end),
        .vs_start     (vs_start),
        .vs_end       (vs_end),
        .above_thresh (above_thresh),
        .pix_tick     (pix_tick),
        .visible      (visible),
        .hsync_i      (hsync_i),
        .vsync_i      (vsync_i),
        .hblank_i     (hblank_i),
        .vblank_i     (vblank_i)
    );

    fetch_engine fetch_engine_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .en           (en),
        .base_addr    (base_addr),
        .line_inc     (line_inc),
        .h_size       (h_size),
        .v_size       (v_size),
        .above_thresh (above_thresh),
        .rd_valid     (rd_valid),
        .req          (req),
        .req_addr     (req_addr)
    );

    pixel_fifo pixel_fifo_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .en           (en),
        .rd_valid     (rd_valid),
        .rd_pixel     (rd_pixel),
        .pop          (pop),
        .head         (head),
        .full         (),
        .empty        (empty),
        .above_thresh (above_thresh),
        .underflow    (underflow)
    );

    pixel_out pixel_out_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .pix_tick  (pix_tick),
        .visible   (visible),
        .hsync_i   (hsync_i),
        .vsync_i   (vsync_i),
        .hblank_i  (hblank_i),
        .vblank_i  (vblank_i),
        .head      (head),
        .empty     (empty),
        .underflow (underflow),
        .pop       (pop),
        .hsync     (hsync),
        .vsync     (vsync),
        .hblank    (hblank),
        .vblank    (vblank),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .underrun  (underrun)
    );

endmodule

//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Frame buffer contents built from every address bit
function automatic logic [31:0] mem_word(logic [31:0] addr);
    logic [31:0] w;
    w = (addr * 32'h9e37_79b1) ^ {addr[12:0], addr[31:13]};
    w[0] = 1'b1; // Keeps every pixel nonblack
    return w;
endfunction

function automatic logic [31:0] word_addr(int line, int col);
    return base + 32'(line) * linc + 32'(4 * col);
endfunction

function automatic pixel_t ref_pixel(int line, int col);
    logic [31:0] w;
    w = mem_word(word_addr(line, col));
    return w[23:0];
endfunction

// {hsync, vsync, hblank, vblank} for one count pair
function automatic logic [3:0] sync_flags(int h, int v);
    logic hs;
    logic vs;
    logic hb;
    logic vb;
    hs = (h >= hss) && (h < hse);
    vs = (v >= vss) && (v < vse);
    hb = (h >= hsz);
    vb = (v >= vsz);
    return {hs, vs, hb, vb};
endfunction

task automatic check_pixel(pixel_t got, pixel_t exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        pix_err++;
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_sync(logic [3:0] got, logic [3:0] exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        sync_err++;
        $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

task automatic check_addr(logic [31:0] got, logic [31:0] exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        addr_err++;
        $display("ERR @%0t: %s got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic check_flag(logic got, logic exp, string what);
    checks++;
    if (got !== exp) begin
        errors++;
        flag_err++;
        $display("ERR @%0t: %s got %b expected %b", $time, what, got, exp);
    end
endtask

`endif

//--- bench/tb_video_ctrl.sv
`timescale 1ns/1ps

module tb_video_ctrl import vid_pkg::*; ();

    logic        clk = 1'b0;
    logic        reset_n = 1'b0;
    cmd_t        cmd_in = cmd_idle;
    logic [31:0] addr_data_in = '0;
    logic        req;
    logic [31:0] req_addr;
    logic        hsync;
    logic        vsync;
    logic        hblank;
    logic        vblank;
    logic [7:0]  red;
    logic [7:0]  green;
    logic [7:0]  blue;
    logic        underrun;

    // Current frame geometry
    int          hsz;
    int          hend;
    int          hss;
    int          hse;
    int          vsz;
    int          vend;
    int          vss;
    int          vse;
    int          div;
    logic [31:0] base;
    logic [31:0] linc;

    int          errors = 0;
    int          checks = 0;
    int          addr_err = 0;
    int          sync_err = 0;
    int          pix_err = 0;
    int          flag_err = 0;
    int          tests_run = 0;
    longint      cycles = 0;
    longint      limit = 400;

    cmd_t        cmd_q[$];
    logic [31:0] data_q[$];
    logic        req_seen = 1'b0;
    logic [31:0] seen_addr;
    logic        resp_due = 1'b0;
    logic [31:0] resp_addr;
    logic        fetch_allowed = 1'b0;
    int          req_word = 0;
    int          req_line = 0;
    logic        compare_on = 1'b0;
    logic        started = 1'b0;
    int          scan_h;
    int          scan_v;
    int          sub_cnt;
    int          frames_seen = 0;

    `include "tb_model.svh"

    video_ctrl video_ctrl_inst (.*);

    initial begin
        forever #50 clk = ~clk;
    end

    // Read data goes out exactly 2 cycles after each req
    always @(negedge clk) begin : bus_driver
        if (resp_due) begin
            cmd_in       <= cmd_read_data;
            addr_data_in <= mem_word(resp_addr);
        end else if (cmd_q.size() != 0) begin
            cmd_in       <= cmd_q.pop_front();
            addr_data_in <= data_q.pop_front();
        end else begin
            cmd_in       <= cmd_idle;
            addr_data_in <= '0;
        end
        resp_due  = req_seen;
        resp_addr = seen_addr;
        req_seen  = req;
        seen_addr = req_addr;
    end

    always @(negedge clk) begin : req_monitor
        if (req && !fetch_allowed) begin
            errors++;
            $display("Read request issued at %0t before the enable bit was written", $time);
        end else if (req) begin
            check_addr(req_addr, word_addr(req_line, req_word), "req_addr");
            req_word++;
            if (req_word == hsz) begin
                req_word = 0;
                req_line = (req_line == vsz - 1) ? 0 : req_line + 1;
            end
        end
    end

    // Locks onto the first nonblack pixel, then steps one tick per pix_div+1 clocks
    always @(negedge clk) begin : compare
        pixel_t     exp_pix;
        logic [3:0] exp_f;
        if (!compare_on) begin
            started     = 1'b0;
            scan_h      = 0;
            scan_v      = 0;
            sub_cnt     = 0;
            frames_seen = 0;
        end else begin
            if (!started) begin
                started = ({red, green, blue} != 24'd0);
            end else if (sub_cnt == div) begin
                sub_cnt = 0;
                if (scan_h == hend) begin
                    scan_h = 0;
                    if (scan_v == vend) begin
                        scan_v = 0;
                        frames_seen++;
                    end else begin
                        scan_v++;
                    end
                end else begin
                    scan_h++;
                end
            end else begin
                sub_cnt++;
            end
            if (started) begin
                exp_f   = sync_flags(scan_h, scan_v);
                exp_pix = (scan_h < hsz && scan_v < vsz) ? ref_pixel(scan_v, scan_h) : '0;
                check_sync({hsync, vsync, hblank, vblank}, exp_f, "sync/blank");
                check_pixel({red, green, blue}, exp_pix, "pixel");
                check_flag(underrun, 1'b0, "underrun");
            end
        end
    end

    initial begin : watchdog
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run stopped after %0d clock cycles", cycles);
        $display("TB FAILED");
        $finish;
    end

    function automatic int frame_cycles();
        return (hend + 1) * (vend + 1) * (div + 1);
    endfunction

    function automatic logic [31:0] span_word(int hi, int lo);
        return ((32'(hi) & 32'h1fff) << 13) | (32'(lo) & 32'h1fff);
    endfunction

    function automatic logic [31:0] ctrl_word(logic e, int d);
        return (32'(d) << ctrl_div_lsb) | (32'(e) << ctrl_en_bit);
    endfunction

    task automatic arm_watchdog(int frames);
        limit = cycles + longint'(frames) * frame_cycles() + 200;
    endtask

    task automatic drain_bus();
        while (cmd_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic write_reg(logic [31:0] addr, logic [31:0] data);
        cmd_q.push_back(cmd_addr);
        data_q.push_back(addr);
        cmd_q.push_back(cmd_write);
        data_q.push_back(data);
        drain_bus();
    endtask

    // Drops en while the output sits in vertical blanking
    task automatic disable_in_vblank();
        cmd_q.push_back(cmd_addr);
        data_q.push_back(addr_ctrl);
        drain_bus();
        while (!vblank) @(negedge clk);
        cmd_q.push_back(cmd_write);
        data_q.push_back(32'd0);
        drain_bus();
        repeat (2) @(negedge clk);
    endtask

    task automatic pick_geometry();
        hsz  = 6 + int'($urandom % 16);
        hend = hsz + 2 + int'($urandom % 4);
        hss  = hsz + 1;
        hse  = hss + 1 + int'($urandom % (hend - hss));
        vsz  = 2 + int'($urandom % 4);
        vend = vsz + 1 + int'($urandom % 2);
        vss  = vsz;
        vse  = vss + 1;
        div  = 3;
        base = $urandom & 32'h00ff_fff0;
        linc = 32'(hsz * 4 + 16 * int'($urandom % 4));
    endtask

    task automatic program_geometry();
        write_reg(addr_h1, span_word(hsz, hend));
        write_reg(addr_h2, span_word(hss, hse));
        write_reg(addr_v1, span_word(vsz, vend));
        write_reg(addr_v2, span_word(vss, vse));
        write_reg(addr_base, base);
        write_reg(addr_lineinc, linc);
    endtask

    task automatic start_scan(int frames, logic cmp);
        req_word      = 0;
        req_line      = 0;
        fetch_allowed = 1'b1;
        compare_on    = cmp;
        arm_watchdog(frames + 1);
        write_reg(addr_ctrl, ctrl_word(1'b1, div));
    endtask

    task automatic report_test(string name, int n_err);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, n_err);
    endtask

    initial begin : main
        int     e0;
        int     a0;
        int     s0;
        int     p0;
        int     f0;
        longint t0;
        pixel_t snap_pix;
        logic [3:0] snap_f;
        void'($urandom(32'h7ad2_66c4));
        repeat (5) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        e0 = errors;
        limit = cycles + 200;
        check_flag(req, 1'b0, "req after reset");
        check_sync({hsync, vsync, hblank, vblank}, 4'b0, "sync after reset");
        check_pixel({red, green, blue}, '0, "rgb after reset");
        check_flag(underrun, 1'b0, "underrun after reset");
        pick_geometry();
        program_geometry();
        repeat (10) @(negedge clk); // Still no req expected
        report_test("reset", errors - e0);

        a0 = addr_err;
        s0 = sync_err;
        p0 = pix_err;
        f0 = flag_err;
        start_scan(2, 1'b1);
        while (frames_seen < 2) @(negedge clk);
        compare_on = 1'b0;
        report_test("request addresses", addr_err - a0);
        report_test("sync and blank", sync_err - s0);
        report_test("pixel data", pix_err - p0 + flag_err - f0);

        // Wide lines at full rate starve the FIFO
        e0 = errors;
        arm_watchdog(2);
        disable_in_vblank();
        hsz  = 32;
        hend = 39;
        hss  = 33;
        hse  = 35;
        vsz  = 3;
        vend = 4;
        vss  = 3;
        vse  = 4;
        div  = 0;
        base = $urandom & 32'h00ff_fff0;
        linc = 32'd256;
        program_geometry();
        start_scan(3, 1'b0);
        t0 = cycles;
        while (!underrun && cycles - t0 < frame_cycles() + 100) @(negedge clk);
        if (!underrun) begin
            errors++;
            $display("Underrun did not rise during the first frame");
        end
        repeat (2 * frame_cycles()) begin
            @(negedge clk);
            check_flag(underrun, 1'b1, "underrun held");
        end
        report_test("underrun", errors - e0);

        e0 = errors;
        arm_watchdog(2);
        disable_in_vblank();
        snap_f   = {hsync, vsync, hblank, vblank};
        snap_pix = {red, green, blue};
        check_pixel(snap_pix, '0, "rgb held in vblank");
        repeat (20) begin
            @(negedge clk);
            check_sync({hsync, vsync, hblank, vblank}, snap_f, "sync while disabled");
            check_pixel({red, green, blue}, snap_pix, "rgb while disabled");
            check_flag(underrun, 1'b0, "underrun while disabled");
            check_flag(req, 1'b0, "req while disabled");
        end
        pick_geometry(); // New base address as well
        program_geometry();
        start_scan(1, 1'b1);
        while (frames_seen < 1) @(negedge clk);
        compare_on = 1'b0;
        report_test("disable and restart", errors - e0);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+bench
design/vid_pkg.sv
design/bus_decode.sv
design/scan_timing.sv
design/fetch_engine.sv
design/pixel_fifo.sv
design/pixel_out.sv
design/video_ctrl.sv
bench/tb_video_ctrl.sv

//--- Makefile
# Verilator build and run for the video controller testbench

SRCS := $(wildcard design/*.sv) bench/tb_video_ctrl.sv bench/tb_model.svh

.PHONY: all compile run clean

all: run

compile: obj_dir/Vtb_video_ctrl

obj_dir/Vtb_video_ctrl: tb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_video_ctrl \
		-f tb.f -o Vtb_video_ctrl

run: compile
	./obj_dir/Vtb_video_ctrl | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
